/* logic/tracker_pkg.sv */
package tracker_pkg;

	// ----------------------------------------------------------------------
	// sizes
	// ----------------------------------------------------------------------

	// lines covered by one expired-bit mask
	localparam int N_LINES      = 16;
	// trace buffer depth, in samples
	localparam int BUFFER_LIMIT = 16;
	// buffer address width
	localparam int BW_BUFFER    = 4;
	// request trace count width
	localparam int TRACE_W      = 32;
	// countdown value after reset, first sample on request FS_INIT+1
	localparam int FS_INIT      = 3;

	// ----------------------------------------------------------------------
	// host config word fields
	// ----------------------------------------------------------------------

	// tracking enable
	localparam int CFG_TRACK_BIT = 24;
	// buffer clear, pulsed by host after readout
	localparam int CFG_CLEAR_BIT = 23;
	// lsb of the host read address
	localparam int CFG_ADDR_LSB  = 4;

	// ----------------------------------------------------------------------
	// types
	// ----------------------------------------------------------------------

	typedef logic [N_LINES-1:0]   line_mask_t;
	typedef logic [TRACE_W-1:0]   trace_count_t;
	typedef logic [BW_BUFFER-1:0] buf_addr_t;
	// one extra bit so a full buffer is representable
	typedef logic [BW_BUFFER:0]   buf_count_t;

	// controller states
	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,
		ST_TRACK = 2'd1,
		ST_FULL  = 2'd2
	} tracker_state_e;

endpackage

/* logic/sample_counter.sv */
`timescale 1ns/1ns

module sample_counter import tracker_pkg::*; (
	input  logic         clock_i,
	input  logic         resetn_i,
	// accepted request strobe from controller
	input  logic         accept_i,
	// countdown reload value
	input  logic [15:0]  rate_i,
	// store one sample this cycle
	output logic         sample_o,
	// trace count including the current request
	output trace_count_t trace_o
);

	// ----------------------------------------------------------------------
	// state
	// ----------------------------------------------------------------------

	// requests remaining until next sample
	logic [15:0]  countdown_q;
	// accepted requests so far
	trace_count_t trace_q;
	// trace count after this cycle
	trace_count_t trace_nxt;

	// countdown expired on an accepted request
	assign sample_o = accept_i && (countdown_q == 16'd0);

	// incremented value visible in the same cycle so the
	// sample written this cycle holds its own request
	assign trace_nxt = trace_q + trace_count_t'(accept_i);
	assign trace_o   = trace_nxt;

	// ----------------------------------------------------------------------
	// counters
	// ----------------------------------------------------------------------

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			countdown_q <= 16'(FS_INIT);
			trace_q     <= '0;
		end else begin
			trace_q <= trace_nxt;
			if (accept_i) begin
				// reload on expiry and step down otherwise
				if (countdown_q == 16'd0) begin
					countdown_q <= rate_i;
				end else begin
					countdown_q <= countdown_q - 16'd1;
				end
			end
		end
	end

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------

	// samples come only from accepted requests
	a_sample_needs_accept : assert property (
		@(posedge clock_i) disable iff (!resetn_i)
		$rose(sample_o) |-> accept_i
	);

endmodule

/* logic/trace_buffer.sv */
`timescale 1ns/1ns

module trace_buffer import tracker_pkg::*; #(
	// entry width, N_LINES for masks or TRACE_W for counts
	parameter int BW_DATA = N_LINES
) (
	input  logic               clock_i,
	// write strobe, read otherwise
	input  logic               wren_i,
	// shared sample or host address
	input  buf_addr_t          addr_i,
	input  logic [BW_DATA-1:0] data_i,
	// registered read data, one cycle after addr_i
	output logic [BW_DATA-1:0] data_o
);

	// ----------------------------------------------------------------------
	// storage
	// ----------------------------------------------------------------------

	// one entry per sample
	logic [BW_DATA-1:0] mem_q [BUFFER_LIMIT];
	// read register
	logic [BW_DATA-1:0] rdata_q;

	// single port
	// write has priority, read register holds during a write
	always_ff @(posedge clock_i) begin
		if (wren_i) begin
			mem_q[addr_i] <= data_i;
		end else begin
			rdata_q <= mem_q[addr_i];
		end
	end

	assign data_o = rdata_q;

endmodule

/* logic/tracker_ctrl.sv */
`timescale 1ns/1ns

module tracker_ctrl import tracker_pkg::*; (
	input  logic        clock_i,
	input  logic        resetn_i,
	// host config word
	input  logic [31:0] config_i,
	// cache request pulse
	input  logic        request_i,
	// sampling enable level
	input  logic        en_i,
	// sample strobe from counter
	input  logic        sample_i,
	// request accepted and steps the counter
	output logic        accept_o,
	// buffer write strobe
	output logic        wren_o,
	// buffer address for sample slot or host read
	output buf_addr_t   addr_o,
	// stored samples
	output buf_count_t  count_o,
	// hold off the cache controller
	output logic        stall_o
);

	// ----------------------------------------------------------------------
	// config decode
	// ----------------------------------------------------------------------

	logic      track;
	logic      clear;
	buf_addr_t host_addr;

	assign track     = config_i[CFG_TRACK_BIT];
	assign clear     = config_i[CFG_CLEAR_BIT];
	assign host_addr = config_i[CFG_ADDR_LSB +: BW_BUFFER];

	// ----------------------------------------------------------------------
	// state
	// ----------------------------------------------------------------------

	tracker_state_e state_q;
	tracker_state_e state_nxt;
	buf_count_t     count_q;
	// this write takes the last free slot
	logic           fill;

	// requests count only while tracking and not stalled
	assign accept_o = request_i && en_i && track && (state_q == ST_TRACK);

	// memories write on the same edge that records the sample
	assign wren_o = sample_i;

	// sampler owns the address while tracking and the host otherwise
	assign addr_o = (state_q == ST_TRACK) ? count_q[BW_BUFFER-1:0] : host_addr;

	assign count_o = count_q;
	assign stall_o = (state_q == ST_FULL);

	assign fill = sample_i && !clear && (count_q == buf_count_t'(BUFFER_LIMIT - 1));

	// next state
	always_comb begin
		state_nxt = state_q;
		unique case (state_q)
			ST_IDLE: begin
				if (track) begin
					state_nxt = ST_TRACK;
				end
			end
			ST_TRACK: begin
				// tracking off wins over a fill
				if (!track) begin
					state_nxt = ST_IDLE;
				end else if (fill) begin
					state_nxt = ST_FULL;
				end
			end
			ST_FULL: begin
				// wait for host readout and clear
				if (clear) begin
					state_nxt = track ? ST_TRACK : ST_IDLE;
				end
			end
			default: begin
				state_nxt = ST_IDLE;
			end
		endcase
	end

	// state and fill count registers
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q <= ST_IDLE;
			count_q <= '0;
		end else begin
			state_q <= state_nxt;
			// clear empties the buffer in any state
			if (clear) begin
				count_q <= '0;
			end else if (wren_o) begin
				count_q <= count_q + buf_count_t'(1);
			end
		end
	end

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------

	// a full buffer never takes another sample
	a_no_write_when_full : assert property (
		@(posedge clock_i) disable iff (!resetn_i)
		(state_q == ST_FULL) |-> !wren_o
	);

	// fill count stays within the buffer
	a_count_in_range : assert property (
		@(posedge clock_i) disable iff (!resetn_i)
		count_q <= buf_count_t'(BUFFER_LIMIT)
	);

endmodule

/* logic/cache_line_tracker.sv */
`timescale 1ns/1ns

module cache_line_tracker import tracker_pkg::*; (
	input  logic         clock_i,
	input  logic         resetn_i,
	// host config word
	input  logic [31:0]  config_i,
	// one cache request per high cycle
	input  logic         request_i,
	// sampling enable
	input  logic         en_i,
	// countdown reload
	input  logic [15:0]  rate_i,
	// expired-bit masks, one per way group
	input  line_mask_t   expired_bits_0_i,
	input  line_mask_t   expired_bits_1_i,
	input  line_mask_t   expired_bits_2_i,
	// cache controller stall
	output logic         stall_o,
	// stored samples
	output buf_count_t   count_o,
	// buffer read data
	output trace_count_t trace_o,
	output line_mask_t   expired_bits_0_o,
	output line_mask_t   expired_bits_1_o,
	output line_mask_t   expired_bits_2_o
);

	// ----------------------------------------------------------------------
	// internal wires
	// ----------------------------------------------------------------------

	logic         accept;
	logic         sample;
	logic         wren;
	buf_addr_t    addr;
	// live trace count into the trace memory
	trace_count_t trace_cnt;

	// control and addressing
	tracker_ctrl u_ctrl (
		.clock_i   (clock_i),
		.resetn_i  (resetn_i),
		.config_i  (config_i),
		.request_i (request_i),
		.en_i      (en_i),
		.sample_i  (sample),
		.accept_o  (accept),
		.wren_o    (wren),
		.addr_o    (addr),
		.count_o   (count_o),
		.stall_o   (stall_o)
	);

	// request count and sampling countdown
	sample_counter u_counter (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.accept_i (accept),
		.rate_i   (rate_i),
		.sample_o (sample),
		.trace_o  (trace_cnt)
	);

	// ----------------------------------------------------------------------
	// trace buffer, four memories on one address
	// ----------------------------------------------------------------------

	// way group 0
	trace_buffer #(
		.BW_DATA (N_LINES)
	) mem_lines0 (
		.clock_i (clock_i),
		.wren_i  (wren),
		.addr_i  (addr),
		.data_i  (expired_bits_0_i),
		.data_o  (expired_bits_0_o)
	);

	// way group 1
	trace_buffer #(
		.BW_DATA (N_LINES)
	) mem_lines1 (
		.clock_i (clock_i),
		.wren_i  (wren),
		.addr_i  (addr),
		.data_i  (expired_bits_1_i),
		.data_o  (expired_bits_1_o)
	);

	// way group 2
	trace_buffer #(
		.BW_DATA (N_LINES)
	) mem_lines2 (
		.clock_i (clock_i),
		.wren_i  (wren),
		.addr_i  (addr),
		.data_i  (expired_bits_2_i),
		.data_o  (expired_bits_2_o)
	);

	// trace count at each sample
	trace_buffer #(
		.BW_DATA (TRACE_W)
	) mem_trace (
		.clock_i (clock_i),
		.wren_i  (wren),
		.addr_i  (addr),
		.data_i  (trace_cnt),
		.data_o  (trace_o)
	);

endmodule

/* verif/tracker_ref.svh */
`ifndef TRACKER_REF_SVH
`define TRACKER_REF_SVH

// ----------------------------------------------------------------------
// reference model stepped once per driven cycle
// ----------------------------------------------------------------------

// expected buffer contents by slot
line_mask_t     ref_mask0 [BUFFER_LIMIT];
line_mask_t     ref_mask1 [BUFFER_LIMIT];
line_mask_t     ref_mask2 [BUFFER_LIMIT];
trace_count_t   ref_trace [BUFFER_LIMIT];
// expected counters and controller state after the next edge
buf_count_t     ref_count     = '0;
trace_count_t   ref_trace_cnt = '0;
logic [15:0]    ref_countdown = 16'(FS_INIT);
tracker_state_e ref_state     = ST_IDLE;

// request counts only while tracking and not stalled
function automatic logic accepts_request(input logic req, input logic en, input logic track);
	return req && en && track && (ref_state == ST_TRACK);
endfunction

// advance the model by one clock with the given inputs
function automatic void step_model(input logic req, input logic en, input logic [31:0] cfg,
	input logic [15:0] rate, input line_mask_t m0, input line_mask_t m1, input line_mask_t m2);
	logic track;
	logic clear;
	track = cfg[CFG_TRACK_BIT];
	clear = cfg[CFG_CLEAR_BIT];
	if (accepts_request(req, en, track)) begin
		ref_trace_cnt = ref_trace_cnt + 1;
		if (ref_countdown == 16'd0) begin
			// sample holds the count of its own request
			ref_mask0[ref_count[BW_BUFFER-1:0]] = m0;
			ref_mask1[ref_count[BW_BUFFER-1:0]] = m1;
			ref_mask2[ref_count[BW_BUFFER-1:0]] = m2;
			ref_trace[ref_count[BW_BUFFER-1:0]] = ref_trace_cnt;
			ref_count = ref_count + 1;
			ref_countdown = rate;
		end else begin
			ref_countdown = ref_countdown - 16'd1;
		end
	end
	if (clear) begin
		ref_count = '0;
	end
	case (ref_state)
		ST_IDLE: begin
			if (track) begin
				ref_state = ST_TRACK;
			end
		end
		ST_TRACK: begin
			if (!track) begin
				ref_state = ST_IDLE;
			end else if (ref_count == buf_count_t'(BUFFER_LIMIT)) begin
				ref_state = ST_FULL;
			end
		end
		default: begin
			if (clear) begin
				ref_state = track ? ST_TRACK : ST_IDLE;
			end
		end
	endcase
endfunction

`endif

/* verif/tracker_tb.sv */
`timescale 1ns/1ns

module tracker_tb import tracker_pkg::*; ();

	localparam int CLK_PERIOD = 20;
	// cycles allowed for any wait
	localparam int WAIT_LIMIT = 4000;

	logic         clock_i;
	logic         resetn_i;
	logic [31:0]  config_i;
	logic         request_i;
	logic         en_i;
	logic [15:0]  rate_i;
	line_mask_t   expired_bits_0_i;
	line_mask_t   expired_bits_1_i;
	line_mask_t   expired_bits_2_i;
	logic         stall_o;
	buf_count_t   count_o;
	trace_count_t trace_o;
	line_mask_t   expired_bits_0_o;
	line_mask_t   expired_bits_1_o;
	line_mask_t   expired_bits_2_o;

	int    seed      = 16;
	int    errors    = 0;
	bit    checking  = 1'b0;
	string test_name = "reset";

	`include "tracker_ref.svh"

	cache_line_tracker cache_line_tracker_i (.*);

	initial clock_i = 1'b0;
	always #(CLK_PERIOD / 2) clock_i = ~clock_i;

	// ----------------------------------------------------------------------
	// failure and compare tasks
	// ----------------------------------------------------------------------

	task automatic abort_run(input string why);
		errors++;
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_count(input string what, input buf_count_t exp, input buf_count_t act);
		if (act !== exp) abort_run($sformatf("ERR %s %s expected %0d actual %0d",
			test_name, what, exp, act));
	endtask

	task automatic check_mask(input string what, input line_mask_t exp, input line_mask_t act);
		if (act !== exp) abort_run($sformatf("ERR %s %s expected %h actual %h",
			test_name, what, exp, act));
	endtask

	task automatic check_trace(input string what, input trace_count_t exp,
		input trace_count_t act);
		if (act !== exp) abort_run($sformatf("ERR %s %s expected %0d actual %0d",
			test_name, what, exp, act));
	endtask

	task automatic check_stall(input string what, input logic exp, input logic act);
		if (act !== exp) abort_run($sformatf("ERR %s %s expected %b actual %b",
			test_name, what, exp, act));
	endtask

	// ----------------------------------------------------------------------
	// stimulus helpers for the falling edge
	// ----------------------------------------------------------------------

	function automatic logic [31:0] cfg_word(input logic track, input logic clear,
		input buf_addr_t addr);
		logic [31:0] w;
		w = '0;
		w[CFG_TRACK_BIT] = track;
		w[CFG_CLEAR_BIT] = clear;
		w[CFG_ADDR_LSB +: BW_BUFFER] = addr;
		return w;
	endfunction

	// drive one cycle and step the model until the next falling edge
	task automatic drive_cycle(input logic req, input logic en, input logic [31:0] cfg,
		input logic [15:0] rate, input line_mask_t m0, input line_mask_t m1,
		input line_mask_t m2);
		request_i        = req;
		en_i             = en;
		config_i         = cfg;
		rate_i           = rate;
		expired_bits_0_i = m0;
		expired_bits_1_i = m1;
		expired_bits_2_i = m2;
		step_model(req, en, cfg, rate, m0, m1, m2);
		@(negedge clock_i);
	endtask

	// random request with enable mostly high and a small rate
	task automatic random_cycle(input logic [31:0] cfg);
		logic [31:0] r;
		line_mask_t  m0;
		line_mask_t  m1;
		line_mask_t  m2;
		r  = $random(seed);
		m0 = line_mask_t'($random(seed));
		m1 = line_mask_t'($random(seed));
		m2 = line_mask_t'($random(seed));
		drive_cycle(r[0], r[2:1] != 2'b00, cfg, 16'(r[4:3]), m0, m1, m2);
	endtask

	task automatic track_until_full();
		int cycles;
		cycles = 0;
		while (!stall_o && cycles < WAIT_LIMIT) begin
			random_cycle(cfg_word(1'b1, 1'b0, '0));
			cycles++;
		end
		if (!stall_o) abort_run($sformatf("timeout in %s, stall_o never rose", test_name));
	endtask

	task automatic track_until_count(input int n);
		int cycles;
		cycles = 0;
		while (ref_count < buf_count_t'(n) && cycles < WAIT_LIMIT) begin
			random_cycle(cfg_word(1'b1, 1'b0, '0));
			cycles++;
		end
		if (ref_count < buf_count_t'(n)) begin
			abort_run($sformatf("timeout in %s, fewer than %0d samples taken", test_name, n));
		end
	endtask

	// host read with data valid one cycle after the address
	task automatic readout_entries(input logic track, input int n);
		buf_addr_t a;
		for (int i = 0; i < n; i++) begin
			a = buf_addr_t'(i);
			drive_cycle(1'b0, 1'b0, cfg_word(track, 1'b0, a), 16'd0, '0, '0, '0);
			check_mask($sformatf("mask0[%0d]", i), ref_mask0[a], expired_bits_0_o);
			check_mask($sformatf("mask1[%0d]", i), ref_mask1[a], expired_bits_1_o);
			check_mask($sformatf("mask2[%0d]", i), ref_mask2[a], expired_bits_2_o);
			check_trace($sformatf("trace[%0d]", i), ref_trace[a], trace_o);
		end
	endtask

	// ----------------------------------------------------------------------
	// comparison process samples mid high phase where outputs are settled
	// ----------------------------------------------------------------------

	initial begin : compare_outputs
		forever begin
			@(posedge clock_i);
			#(CLK_PERIOD / 4);
			if (checking) begin
				check_count("count_o", ref_count, count_o);
				check_stall("stall_o", ref_state == ST_FULL, stall_o);
			end
		end
	end

	// ----------------------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------------------

	initial begin : run_tests
		buf_count_t held;
		resetn_i         = 1'b0;
		config_i         = '0;
		request_i        = 1'b0;
		en_i             = 1'b0;
		rate_i           = '0;
		expired_bits_0_i = '0;
		expired_bits_1_i = '0;
		expired_bits_2_i = '0;
		repeat (4) @(posedge clock_i);
		@(negedge clock_i);
		resetn_i = 1'b1;
		check_stall("stall_o", 1'b0, stall_o);
		check_count("count_o", '0, count_o);
		checking = 1'b1;

		test_name = "fill_random";
		track_until_full();
		check_count("count_o", buf_count_t'(BUFFER_LIMIT), count_o);

		// requests while stalled are dropped
		test_name = "stalled_requests";
		repeat (8) drive_cycle(1'b1, 1'b1, cfg_word(1'b1, 1'b0, '0), 16'd0, '1, '1, '1);
		check_count("count_o", buf_count_t'(BUFFER_LIMIT), count_o);

		test_name = "readout_full";
		readout_entries(1'b1, BUFFER_LIMIT);

		test_name = "clear";
		drive_cycle(1'b0, 1'b0, cfg_word(1'b1, 1'b1, '0), 16'd0, '0, '0, '0);
		check_stall("stall_o", 1'b0, stall_o);
		check_count("count_o", '0, count_o);
		track_until_count(4);

		// requests with the track bit low must not count
		test_name = "track_off";
		held = ref_count;
		repeat (40) random_cycle(cfg_word(1'b0, 1'b0, '0));
		check_count("count_o", held, count_o);
		readout_entries(1'b0, int'(held));

		test_name = "resume";
		track_until_full();
		readout_entries(1'b1, BUFFER_LIMIT);

		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* cache_tracker.f */
+incdir+verif
logic/tracker_pkg.sv
logic/sample_counter.sv
logic/trace_buffer.sv
logic/tracker_ctrl.sv
logic/cache_line_tracker.sv
verif/tracker_tb.sv

/* Makefile */
# Verilator build and run for the cache line tracker

VERILATOR ?= verilator
TOP       ?= tracker_tb
FILELIST  ?= cache_tracker.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

# pass only when the testbench prints the pass message
run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
